/* common/isa_pkg.sv */
// RV32I subset definitions
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes, HALT uses the all-ones pattern
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        HALT   = 7'b1111111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // Decoded control
    // Unused source fields are zero so they never hit a busy bit
    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne;
        logic      halt;
    } ctrl_t;

endpackage

/* common/pipeline_pkg.sv */
// Pipeline latch and cache port types
package pipeline_pkg;

    import isa_pkg::*;

    // Fetch to dispatch
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fd_t;

    // Issue to execute
    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t rdat1;
        word_t rdat2;
    } ie_t;

    // Execute to writeback, wdata is already the final value
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      reg_write;
        word_t     wdata;
    } ew_t;

    typedef struct packed {
        word_t imem_addr;
        logic  dmem_ren;
        logic  dmem_wen;
        word_t dmem_addr;
        word_t dmem_store;
        logic  halt;
    } cache_req_t;

    typedef struct packed {
        logic  ihit;
        word_t imem_load;
        logic  dhit;
        word_t dmem_load;
    } cache_rsp_t;

endpackage

/* fetch/fetch.sv */
// Program counter and fetch
`timescale 1ns/1ps

module fetch
    import isa_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  CLK,
    input  logic  nrst,
    input  logic  ihit,
    input  logic  freeze,
    input  logic  redirect,
    input  word_t target,
    input  word_t imem_load,
    output word_t pc,
    output word_t instr
);

    // Redirect wins over freeze so a taken branch is never lost
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (ihit && !freeze) begin
            pc <= pc + 32'd4;
        end
    end

    // Fetched word goes straight to the dispatch latch
    assign instr = imem_load;

endmodule

/* dispatch/dispatch.sv */
// Instruction decoder
`timescale 1ns/1ps

module dispatch
    import isa_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    logic [2:0] funct3;
    logic       funct7_5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;

    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        // Start from a no-operation
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;

        case (opcode_t'(instr[6:0]))
            OP, OP_IMM: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rd        = instr[11:7];
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = (instr[6:0] == OP_IMM);
                if (ctrl.use_imm) begin
                    ctrl.imm = imm_i;
                end else begin
                    ctrl.rs2 = instr[24:20];
                end
                case (funct3)
                    3'b000: begin
                        // SUB only exists in the register form
                        ctrl.alu_op = (funct7_5 && !ctrl.use_imm) ? ALU_SUB : ALU_ADD;
                    end
                    3'b111: ctrl.alu_op = ALU_AND;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    default: ctrl = '0;
                endcase
            end
            LOAD: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rd        = instr[11:7];
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_i;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            STORE: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_s;
                ctrl.mem_write = 1'b1;
            end
            BRANCH: begin
                // BEQ and BNE only
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.rs1       = instr[19:15];
                    ctrl.rs2       = instr[24:20];
                    ctrl.imm       = imm_b;
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                end
            end
            HALT: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

/* dispatch/scoreboard.sv */
// Register busy scoreboard
`timescale 1ns/1ps

module scoreboard
    import isa_pkg::*;
(
    input  logic      CLK,
    input  logic      nrst,
    input  ctrl_t     ctrl,
    input  logic      valid,
    input  logic      issue,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    output logic      freeze
);

    logic [31:0] busy;
    logic [31:0] busy_now;

    // Writeback in this cycle already releases its register
    always_comb begin
        busy_now = busy;
        if (wb_valid) begin
            busy_now[wb_rd] = 1'b0;
        end
    end

    assign freeze = valid && (busy_now[ctrl.rs1] || busy_now[ctrl.rs2] ||
                              (ctrl.reg_write && busy_now[ctrl.rd]));

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            // Set after clear so a reissue to the same rd stays busy
            if (issue && ctrl.reg_write && ctrl.rd != '0) begin
                busy[ctrl.rd] <= 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nrst) issue |-> !freeze)
        else $error("issue while scoreboard freeze is high");

    // Every writeback must retire a register that was marked at issue
    assert property (@(posedge CLK) disable iff (!nrst)
        (wb_valid && wb_rd != '0) |-> busy[wb_rd])
        else $error("writeback to register %0d that was not busy", wb_rd);

endmodule

/* rtl/regfile.sv */
// Register file
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
(
    input  logic      CLK,
    input  logic      nrst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      wen,
    input  reg_addr_t wsel,
    input  word_t     wdat,
    output word_t     rdat1,
    output word_t     rdat2
);

    word_t regs [32];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            regs <= '{default: '0};
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    // Same-cycle write is visible to the reader
    assign rdat1 = (rs1 == '0) ? '0 : (wen && wsel == rs1) ? wdat : regs[rs1];
    assign rdat2 = (rs2 == '0) ? '0 : (wen && wsel == rs2) ? wdat : regs[rs2];

endmodule

/* execute/execute.sv */
// Execute stage
`timescale 1ns/1ps

module execute
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input  logic       CLK,
    input  logic       nrst,
    input  ie_t        ie,
    input  cache_rsp_t rsp,
    output logic       dmem_ren,
    output logic       dmem_wen,
    output word_t      dmem_addr,
    output word_t      dmem_store,
    output logic       mem_wait,
    output logic       redirect,
    output word_t      target,
    output ew_t        ew,
    output logic       halt
);

    typedef enum logic {IDLE, ACCESS} mem_state_t;

    mem_state_t state;
    logic       mem_op;
    logic       halt_q;
    word_t      op_b;
    word_t      alu_out;
    logic       equal;

    assign op_b = ie.ctrl.use_imm ? ie.ctrl.imm : ie.rdat2;

    always_comb begin
        case (ie.ctrl.alu_op)
            ALU_SUB: alu_out = ie.rdat1 - op_b;
            ALU_AND: alu_out = ie.rdat1 & op_b;
            ALU_OR:  alu_out = ie.rdat1 | op_b;
            ALU_XOR: alu_out = ie.rdat1 ^ op_b;
            ALU_SLT: alu_out = {31'd0, $signed(ie.rdat1) < $signed(op_b)};
            default: alu_out = ie.rdat1 + op_b;
        endcase
    end

    // Branches resolve here, not-taken needs no action
    assign equal    = (ie.rdat1 == ie.rdat2);
    assign redirect = ie.valid && ie.ctrl.branch && (ie.ctrl.branch_ne ? !equal : equal);
    assign target   = ie.pc + ie.ctrl.imm;

    // One idle cycle first so the request drops between accesses
    assign mem_op = ie.valid && (ie.ctrl.mem_read || ie.ctrl.mem_write);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (mem_op) state <= ACCESS;
                ACCESS:  if (rsp.dhit) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign dmem_ren   = (state == ACCESS) && mem_op && ie.ctrl.mem_read;
    assign dmem_wen   = (state == ACCESS) && mem_op && ie.ctrl.mem_write;
    assign dmem_addr  = alu_out;
    assign dmem_store = ie.rdat2;
    assign mem_wait   = mem_op && !(state == ACCESS && rsp.dhit);

    // Halt is sticky once seen
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_q <= 1'b0;
        end else if (ie.valid && ie.ctrl.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halt = halt_q || (ie.valid && ie.ctrl.halt);

    assign ew.valid     = ie.valid && !mem_wait && !ie.ctrl.halt;
    assign ew.rd        = ie.ctrl.rd;
    assign ew.reg_write = ie.ctrl.reg_write;
    assign ew.wdata     = ie.ctrl.mem_read ? rsp.dmem_load : alu_out;

    assert property (@(posedge CLK) disable iff (!nrst) !(dmem_ren && dmem_wen))
        else $error("dmem_ren and dmem_wen both high");

    // A pending request keeps its address until the hit
    assert property (@(posedge CLK) disable iff (!nrst)
        ((dmem_ren || dmem_wen) && !rsp.dhit) |=>
            ((dmem_ren || dmem_wen) && $stable(dmem_addr) && $stable(dmem_store)))
        else $error("data request changed before dhit");

endmodule

/* rtl/sc_datapath.sv */
// Scalar pipeline datapath top
`timescale 1ns/1ps

module sc_datapath
    import isa_pkg::*;
    import pipeline_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic       CLK,
    input  logic       nrst,
    output cache_req_t cache_req,
    input  cache_rsp_t cache_rsp
);

    word_t pc;
    word_t instr;
    ctrl_t ctrl;
    word_t rdat1;
    word_t rdat2;
    logic  freeze;
    logic  stall;
    logic  issue;
    logic  redirect;
    word_t target;
    logic  mem_wait;
    logic  halt;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;

    fd_t fd_q;
    ie_t ie_d;
    ie_t ie_q;
    ew_t ew_d;
    ew_t ew_q;

    // Execute holds everything behind it during a memory access or after halt
    assign stall = mem_wait || halt;
    assign issue = fd_q.valid && !freeze && !stall && !redirect;

    fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .CLK       (CLK),
        .nrst      (nrst),
        .ihit      (cache_rsp.ihit),
        .freeze    (freeze || stall),
        .redirect  (redirect),
        .target    (target),
        .imem_load (cache_rsp.imem_load),
        .pc        (pc),
        .instr     (instr)
    );

    dispatch u_dispatch (
        .instr (fd_q.instr),
        .ctrl  (ctrl)
    );

    scoreboard u_scoreboard (
        .CLK      (CLK),
        .nrst     (nrst),
        .ctrl     (ctrl),
        .valid    (fd_q.valid),
        .issue    (issue),
        .wb_valid (ew_q.valid && ew_q.reg_write),
        .wb_rd    (ew_q.rd),
        .freeze   (freeze)
    );

    regfile u_regfile (
        .CLK   (CLK),
        .nrst  (nrst),
        .rs1   (ctrl.rs1),
        .rs2   (ctrl.rs2),
        .wen   (ew_q.valid && ew_q.reg_write),
        .wsel  (ew_q.rd),
        .wdat  (ew_q.wdata),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    execute u_execute (
        .CLK        (CLK),
        .nrst       (nrst),
        .ie         (ie_q),
        .rsp        (cache_rsp),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .mem_wait   (mem_wait),
        .redirect   (redirect),
        .target     (target),
        .ew         (ew_d),
        .halt       (halt)
    );

    always_comb begin
        ie_d.valid = issue;
        ie_d.pc    = fd_q.pc;
        ie_d.ctrl  = ctrl;
        ie_d.rdat1 = rdat1;
        ie_d.rdat2 = rdat2;
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fd_q <= '0;
            ie_q <= '0;
            ew_q <= '0;
        end else begin
            // Taken branch kills the two younger instructions
            if (redirect) begin
                fd_q.valid <= 1'b0;
            end else if (!freeze && !stall) begin
                fd_q.valid <= cache_rsp.ihit;
                fd_q.pc    <= pc;
                fd_q.instr <= instr;
            end

            if (redirect) begin
                ie_q.valid <= 1'b0;
            end else if (!stall) begin
                ie_q <= ie_d;
            end

            ew_q <= ew_d;
        end
    end

    always_comb begin
        cache_req.imem_addr  = pc;
        cache_req.dmem_ren   = dmem_ren;
        cache_req.dmem_wen   = dmem_wen;
        cache_req.dmem_addr  = dmem_addr;
        cache_req.dmem_store = dmem_store;
        cache_req.halt       = halt;
    end

endmodule

/* tests/sc_datapath_tb.sv */
// Datapath testbench
`timescale 1ns/1ps

module sc_datapath_tb
    import isa_pkg::*;
    import pipeline_pkg::*;
();

    localparam word_t HALT_WORD   = 32'h0000_007F;
    localparam int    COUNT_INDEX = 256;

    logic       CLK;
    logic       nrst;
    logic       live;
    cache_req_t req;
    cache_rsp_t rsp;

    word_t  test_data [0:511];
    word_t  dmem [0:255];
    integer seed = 76212;
    int     prog_words = 0;
    int     exp_count = 0;
    int     store_count = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     i_wait = 0;
    int     d_wait = 0;

    sc_datapath #(.RESET_PC(32'h0)) dut (
        .CLK       (CLK),
        .nrst      (nrst),
        .cache_req (req),
        .cache_rsp (rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic int random_delay();
        return 1 + ($unsigned($random(seed)) % 3);
    endfunction

    // Data memory contents before any store
    function automatic word_t fill_word(input int index);
        return 32'hA500_0000 ^ (word_t'(index * 4) * 32'h0001_0001);
    endfunction

    // Past the end of the program the memory returns HALT
    function automatic word_t fetch_word(input word_t addr);
        word_t word;
        word = HALT_WORD;
        if (addr[31:2] < prog_words) begin
            word = test_data[addr[31:2]];
        end
        return word;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d value errors, %0d other errors, %0d stores seen",
                 value_errors, other_errors, store_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Expected pairs follow the count word
    task automatic record_store(input word_t addr, input word_t data);
        int base;
        if (req.halt) begin
            other_errors++;
            $display("A store to address %h was seen while halt was high", addr);
        end
        if (store_count >= exp_count) begin
            other_errors++;
            $display("Store to address %h with data %h came beyond the %0d expected stores",
                     addr, data, exp_count);
        end else begin
            base = COUNT_INDEX + 1 + 2 * store_count;
            check_word($sformatf("store %0d address", store_count), test_data[base], addr);
            check_word($sformatf("store %0d data", store_count), test_data[base + 1], data);
        end
        store_count++;
    endtask

    task automatic serve_fetch();
        if (i_wait == 0) begin
            i_wait = random_delay();
        end
        i_wait--;
        if (i_wait == 0) begin
            rsp.ihit      = 1'b1;
            rsp.imem_load = fetch_word(req.imem_addr);
        end
    endtask

    task automatic serve_data();
        if (req.dmem_ren || req.dmem_wen) begin
            if (d_wait == 0) begin
                d_wait = random_delay();
            end
            d_wait--;
            if (d_wait == 0) begin
                rsp.dhit = 1'b1;
                if (req.dmem_wen) begin
                    record_store(req.dmem_addr, req.dmem_store);
                    dmem[req.dmem_addr[9:2]] = req.dmem_store;
                end else begin
                    rsp.dmem_load = dmem[req.dmem_addr[9:2]];
                end
            end
        end
    endtask

    // Memory model with one-cycle strobes
    always @(posedge CLK) begin
        live = nrst;
        #2;
        rsp.ihit = 1'b0;
        rsp.dhit = 1'b0;
        if (live) begin
            serve_fetch();
            serve_data();
        end
    end

    initial begin
        rsp  = '0;
        nrst = 1'b0;
        $readmemh("tests/program_input.hex", test_data);
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        while (prog_words < COUNT_INDEX && !$isunknown(test_data[prog_words])) begin
            prog_words++;
        end
        if (prog_words == 0) begin
            other_errors++;
            $display("The program file holds no instruction words");
            finish_run();
        end else begin
            exp_count = test_data[COUNT_INDEX];
            repeat (3) @(posedge CLK);
            #2 nrst = 1'b1;
            do begin
                @(negedge CLK);
            end while (req.halt !== 1'b1);
            // Give a late store the chance to show up
            repeat (20) @(negedge CLK);
            check_word("store count", exp_count, store_count);
            finish_run();
        end
    end

    initial begin : watchdog
        int limit;
        wait (prog_words > 0);
        limit = prog_words * 40 * 4;
        repeat (limit) @(posedge CLK);
        other_errors++;
        $display("Timeout: halt never came within %0d cycles", limit);
        finish_run();
    end

endmodule

/* tests/program_input.hex */
// From @000 one program word per line
// At @100 the expected store count, then one store per line as address and data
@000
00500093  // addi x1, x0, 5
FF400113  // addi x2, x0, -12
002081B3  // add  x3, x1, x2
40208233  // sub  x4, x1, x2
0041C2B3  // xor  x5, x3, x4
0040E333  // or   x6, x1, x4
004173B3  // and  x7, x2, x4
0011A433  // slt  x8, x3, x1
10302023  // sw   x3, 0x100(x0)
10402223  // sw   x4, 0x104(x0)
10502423  // sw   x5, 0x108(x0)
10602623  // sw   x6, 0x10c(x0)
10702823  // sw   x7, 0x110(x0)
10802A23  // sw   x8, 0x114(x0)
04002483  // lw   x9, 0x040(x0)
12348493  // addi x9, x9, 0x123
10902C23  // sw   x9, 0x118(x0)
06300013  // addi x0, x0, 99
10002E23  // sw   x0, 0x11c(x0)
00108663  // beq  x1, x1, +12 taken
1E102823  // sw   x1, 0x1f0(x0) skipped
1E102A23  // sw   x1, 0x1f4(x0) skipped
00209663  // bne  x1, x2, +12 taken
1E202C23  // sw   x2, 0x1f8(x0) skipped
1E202E23  // sw   x2, 0x1fc(x0) skipped
00208463  // beq  x1, x2, +8 not taken
12602023  // sw   x6, 0x120(x0)
00109463  // bne  x1, x1, +8 not taken
12702223  // sw   x7, 0x124(x0)
0000007F  // halt
12102423  // sw   x1, 0x128(x0) after halt
@100
0000000A
00000100 FFFFFFF9
00000104 00000011
00000108 FFFFFFE8
0000010C 00000015
00000110 00000010
00000114 00000001
00000118 A5400163
0000011C 00000000
00000120 00000015
00000124 00000010

/* list.f */
common/isa_pkg.sv
common/pipeline_pkg.sv
fetch/fetch.sv
dispatch/dispatch.sv
dispatch/scoreboard.sv
rtl/regfile.sv
execute/execute.sv
rtl/sc_datapath.sv
tests/sc_datapath_tb.sv
